// File: design/ray_delta_pkg.sv
////////////////////////////////////////
// Ray delta package
// Axis count, default fixed-point format and
// the per-lane flag types shared by the stage
////////////////////////////////////////

package ray_delta_pkg;

  // Two axes, X and Y, one reciprocal lane each
  localparam int NUM_AXES = 2;

  // Default SQ12.12 format
  localparam int Q_INT_DEF  = 12;  // Integer bits, sign included
  localparam int Q_FRAC_DEF = 12;  // Fractional bits

  // Leading-zero count or signed rescale amount
  // 6 bits is enough for formats up to 32 bits in total
  typedef logic [5:0] shift_t;

  // Axis index, 0 is X and 1 is Y
  typedef logic [0:0] axis_t;

  // Operand flags made by the issue block and carried down each lane
  typedef struct packed {
    logic neg;   // Operand sign, later the step direction
    logic zero;  // Operand is exactly zero
  } lane_flags_t;

  // Flag output of one lane
  typedef struct packed {
    lane_flags_t flags;  // Flags passed through from issue
    logic        sat;    // Result was clamped to the largest positive value
  } lane_res_t;

endpackage

// File: design/ray_dir_issue.sv
////////////////////////////////////////
// Ray direction issue
// Registers the ray direction, puts it into lane
// order and makes sign and zero flags per axis
////////////////////////////////////////

`timescale 1ns/1ps

module ray_dir_issue #(
  parameter int Q_INT  = ray_delta_pkg::Q_INT_DEF,   // Integer bits, sign included
  parameter int Q_FRAC = ray_delta_pkg::Q_FRAC_DEF   // Fractional bits
) (
  input  logic                                                  i_clk,
  input  logic                                                  i_rst_n,
  input  logic                                                  i_ray_valid,
  input  logic signed [Q_INT+Q_FRAC-1:0]                        i_dir_x,
  input  logic signed [Q_INT+Q_FRAC-1:0]                        i_dir_y,
  output logic [ray_delta_pkg::NUM_AXES-1:0]                    o_lane_valid,
  output logic [ray_delta_pkg::NUM_AXES-1:0][Q_INT+Q_FRAC-1:0]  o_lane_data,
  output ray_delta_pkg::lane_flags_t [ray_delta_pkg::NUM_AXES-1:0] o_lane_flags
);
  import ray_delta_pkg::*;

  localparam int W = Q_INT + Q_FRAC;  // Full operand width

  logic [NUM_AXES-1:0][W-1:0] dir_in;    // Directions in lane order
  lane_flags_t [NUM_AXES-1:0] flags_in;  // Flags before the register

  assign dir_in = {i_dir_y, i_dir_x};  // Lane 0 takes X, lane 1 takes Y

  // Sign and exact-zero detect so the lanes get ready-made flags
  always_comb begin
    for (int k = 0; k < NUM_AXES; k++) begin
      flags_in[k].neg  = dir_in[k][W-1];  // Sign bit is the step direction
      flags_in[k].zero = ~|dir_in[k];
    end
  end

  // Valid strobe, one copy per lane
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_lane_valid <= '0;
    end else begin
      o_lane_valid <= {NUM_AXES{i_ray_valid}};
    end
  end

  // Payload follows the strobe every cycle
  always_ff @(posedge i_clk) begin
    o_lane_data  <= dir_in;
    o_lane_flags <= flags_in;
  end

  // A lane valid is only ever the echo of a strobe one cycle back
  a_valid_from_strobe: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    |o_lane_valid |-> $past(i_ray_valid)
  );

endmodule

// File: design/reciprocal_lane.sv
////////////////////////////////////////
// Reciprocal lane
// Two-stage absolute reciprocal of one SQm.n
// value normalized to [0.5,1) and saturated
////////////////////////////////////////

`timescale 1ns/1ps

module reciprocal_lane #(
  parameter int Q_INT  = ray_delta_pkg::Q_INT_DEF,   // Integer bits including the sign
  parameter int Q_FRAC = ray_delta_pkg::Q_FRAC_DEF   // Fractional bits
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  logic [Q_INT+Q_FRAC-1:0]     i_data,   // Signed operand
  input  ray_delta_pkg::lane_flags_t  i_flags,
  output logic                        o_valid,
  output logic [Q_INT+Q_FRAC-1:0]     o_data,   // Magnitude that is never negative
  output ray_delta_pkg::lane_res_t    o_res
);
  import ray_delta_pkg::*;

  localparam int W         = Q_INT + Q_FRAC;
  localparam int SHIFT_MSB = $bits(shift_t) - 1;  // Sign bit of a rescale amount
  localparam int MID_HI    = W + Q_FRAC - 1;       // Top of the SQm.n slice of a product

  // Polynomial constants in SQm.n truncated toward zero
  localparam real SCALE = 2.0 ** Q_FRAC;
  localparam logic [W-1:0] N1466  = W'($rtoi(1.466 * SCALE));   // 1.466
  localparam logic [W-1:0] N10012 = W'($rtoi(1.0012 * SCALE));  // 1.0012
  localparam logic [W-1:0] NSAT   = {1'b0, {(W-1){1'b1}}};      // Largest positive value

  // Stage 1 signals
  logic [W-1:0] mag;         // Two's-complement magnitude
  shift_t       lzc;         // Leading zeros of mag
  shift_t       rescale;     // Signed Q_INT - lzc
  shift_t       norm_left;   // Left shift when rescale is negative
  logic [W-1:0] norm;        // mag moved into [0.5,1)

  logic         s1_valid;
  logic [W-1:0] s1_norm;
  shift_t       s1_rescale;
  lane_flags_t  s1_flags;

  // Stage 2 signals
  logic [W-1:0]          b;        // 1.466 - a
  logic signed [2*W-1:0] c_full;   // a * b
  logic [W-1:0]          d;        // 1.0012 - a*b
  logic signed [2*W-1:0] e_full;   // d * b
  logic [W-1:0]          f;        // e back in SQm.n
  logic [W-1:0]          reci;     // e * 4 or clamp
  shift_t                back_left;
  logic [2*W-1:0]        wide;     // Rescaled result with overflow room
  logic                  sat;
  logic [W-1:0]          res_data;

  // Stage 1 takes the magnitude and normalizes by leading zeros
  always_comb begin
    mag = i_flags.neg ? (~i_data + 1'b1) : i_data;  // Most negative value stays as 2^(W-1)

    // Priority over all bits where the highest set bit wins
    lzc = shift_t'(W);  // No bit set for a zero operand
    for (int i = 0; i < W; i++) begin
      if (mag[i]) lzc = shift_t'(W - 1 - i);
    end

    // Leading one sits at bit Q_FRAC-1 once normalized
    rescale   = shift_t'(Q_INT) - lzc;
    norm_left = shift_t'(-rescale);
    if (rescale[SHIFT_MSB]) begin
      norm = mag << norm_left;  // Small value scales up
    end else begin
      norm = mag >> rescale;    // Leading one in the integer part scales down
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    s1_norm    <= norm;
    s1_rescale <= rescale;
    s1_flags   <= i_flags;
  end

  // Stage 2 runs the polynomial on a in [0.5,1) and rescales
  always_comb begin
    b      = N1466 - s1_norm;
    c_full = $signed(s1_norm) * $signed(b);
    d      = N10012 - c_full[MID_HI:Q_FRAC];
    e_full = $signed(d) * $signed(b);
    f      = e_full[MID_HI:Q_FRAC];

    // Top two bits would fall off in the times-4
    reci = (|f[W-1:W-2]) ? NSAT : (f << 2);

    // Undo the normalization in the opposite direction to stage 1
    wide      = {{W{1'b0}}, reci};
    back_left = shift_t'(-s1_rescale);
    if (s1_rescale[SHIFT_MSB]) begin
      wide = wide << back_left;
    end else begin
      wide = wide >> s1_rescale;
    end

    // Anything at or above the sign bit of the result is overflow
    sat      = s1_flags.zero | (|wide[2*W-1:W-1]);
    res_data = sat ? NSAT : wide[W-1:0];
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_data      <= res_data;
    o_res.flags <= s1_flags;  // Step sign travels with the result
    o_res.sat   <= sat;
  end

  // Magnitude output only
  a_never_negative: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_valid |-> !o_data[W-1]
  );

  // A raised sat always comes with the clamp value
  a_sat_clamps: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_valid && o_res.sat) |-> (o_data == NSAT)
  );

endmodule

// File: design/delta_dist_pack.sv
////////////////////////////////////////
// Delta distance pack
// Registers both lane results per axis and
// picks the axis the walker steps first
////////////////////////////////////////

`timescale 1ns/1ps

module delta_dist_pack #(
  parameter int Q_INT  = ray_delta_pkg::Q_INT_DEF,   // Integer bits including the sign
  parameter int Q_FRAC = ray_delta_pkg::Q_FRAC_DEF   // Fractional bits
) (
  input  logic                                                  i_clk,
  input  logic                                                  i_rst_n,
  input  logic [ray_delta_pkg::NUM_AXES-1:0]                    i_lane_valid,
  input  logic [ray_delta_pkg::NUM_AXES-1:0][Q_INT+Q_FRAC-1:0]  i_lane_data,
  input  ray_delta_pkg::lane_res_t [ray_delta_pkg::NUM_AXES-1:0] i_lane_res,
  output logic                                                  o_delta_valid,
  output logic [Q_INT+Q_FRAC-1:0]                               o_delta_x,
  output logic [Q_INT+Q_FRAC-1:0]                               o_delta_y,
  output logic                                                  o_step_neg_x,
  output logic                                                  o_step_neg_y,
  output logic                                                  o_sat_x,
  output logic                                                  o_sat_y,
  output logic                                                  o_near_x
);
  import ray_delta_pkg::*;

  localparam axis_t AX_X = axis_t'(0);
  localparam axis_t AX_Y = axis_t'(1);

  logic lane_valid;  // Lanes run in lockstep so X stands for both
  logic near_x;      // Delta X no larger than delta Y

  assign lane_valid = i_lane_valid[AX_X];

  // Unsigned magnitude compare where a tie goes to X
  assign near_x = (i_lane_data[AX_X] <= i_lane_data[AX_Y]);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_delta_valid <= 1'b0;
      o_delta_x     <= '0;
      o_delta_y     <= '0;
      o_step_neg_x  <= 1'b0;
      o_step_neg_y  <= 1'b0;
      o_sat_x       <= 1'b0;
      o_sat_y       <= 1'b0;
      o_near_x      <= 1'b0;
    end else begin
      o_delta_valid <= lane_valid;
      if (lane_valid) begin  // Hold the last ray between strobes
        o_delta_x    <= i_lane_data[AX_X];
        o_delta_y    <= i_lane_data[AX_Y];
        o_step_neg_x <= i_lane_res[AX_X].flags.neg;
        o_step_neg_y <= i_lane_res[AX_Y].flags.neg;
        o_sat_x      <= i_lane_res[AX_X].sat;
        o_sat_y      <= i_lane_res[AX_Y].sat;
        o_near_x     <= near_x;
      end
    end
  end

  // Both lanes must deliver in the same cycle
  a_lanes_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (&i_lane_valid) == (|i_lane_valid)
  );

endmodule

// File: design/ray_delta_unit.sv
////////////////////////////////////////
// Ray delta unit
// Ray-step setup, per-axis delta distance,
// step direction and nearer axis, 4 cycles
////////////////////////////////////////

`timescale 1ns/1ps

module ray_delta_unit #(
  parameter int Q_INT  = ray_delta_pkg::Q_INT_DEF,   // Integer bits, sign included
  parameter int Q_FRAC = ray_delta_pkg::Q_FRAC_DEF   // Fractional bits
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_ray_valid,   // One-cycle strobe
  input  logic signed [Q_INT+Q_FRAC-1:0] i_dir_x,
  input  logic signed [Q_INT+Q_FRAC-1:0] i_dir_y,
  output logic                           o_delta_valid,
  output logic [Q_INT+Q_FRAC-1:0]        o_delta_x,
  output logic [Q_INT+Q_FRAC-1:0]        o_delta_y,
  output logic                           o_step_neg_x,
  output logic                           o_step_neg_y,
  output logic                           o_sat_x,
  output logic                           o_sat_y,
  output logic                           o_near_x
);
  import ray_delta_pkg::*;

  localparam int W = Q_INT + Q_FRAC;

  // Issue to lanes
  logic [NUM_AXES-1:0]        issue_valid;
  logic [NUM_AXES-1:0][W-1:0] issue_data;
  lane_flags_t [NUM_AXES-1:0] issue_flags;

  // Lanes to pack
  logic [NUM_AXES-1:0]        lane_valid;
  logic [NUM_AXES-1:0][W-1:0] lane_data;
  lane_res_t [NUM_AXES-1:0]   lane_res;

  ray_dir_issue #(
    .Q_INT  (Q_INT),
    .Q_FRAC (Q_FRAC)
  ) u_issue (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_ray_valid  (i_ray_valid),
    .i_dir_x      (i_dir_x),
    .i_dir_y      (i_dir_y),
    .o_lane_valid (issue_valid),
    .o_lane_data  (issue_data),
    .o_lane_flags (issue_flags)
  );

  // One reciprocal lane per axis
  for (genvar k = 0; k < NUM_AXES; k++) begin : g_lane
    localparam axis_t AXIS = axis_t'(k);

    reciprocal_lane #(
      .Q_INT  (Q_INT),
      .Q_FRAC (Q_FRAC)
    ) u_lane (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_valid (issue_valid[AXIS]),
      .i_data  (issue_data[AXIS]),
      .i_flags (issue_flags[AXIS]),
      .o_valid (lane_valid[AXIS]),
      .o_data  (lane_data[AXIS]),
      .o_res   (lane_res[AXIS])
    );
  end

  delta_dist_pack #(
    .Q_INT  (Q_INT),
    .Q_FRAC (Q_FRAC)
  ) u_pack (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_lane_valid  (lane_valid),
    .i_lane_data   (lane_data),
    .i_lane_res    (lane_res),
    .o_delta_valid (o_delta_valid),
    .o_delta_x     (o_delta_x),
    .o_delta_y     (o_delta_y),
    .o_step_neg_x  (o_step_neg_x),
    .o_step_neg_y  (o_step_neg_y),
    .o_sat_x       (o_sat_x),
    .o_sat_y       (o_sat_y),
    .o_near_x      (o_near_x)
  );

endmodule

// File: dv/tb_ray_delta_unit.sv
////////////////////////////////////////
// Ray delta unit testbench
// Directed and xorshift rays against a
// real-valued reciprocal model
////////////////////////////////////////

`timescale 1ns/1ps

module tb_ray_delta_unit;
  import ray_delta_pkg::*;

  localparam int  Q_INT   = Q_INT_DEF;
  localparam int  Q_FRAC  = Q_FRAC_DEF;
  localparam int  W       = Q_INT + Q_FRAC;
  localparam int  LATENCY = 4;                       // Strobe to o_delta_valid
  localparam int  DRAIN_MAX = 20;                    // Cycles allowed to empty the pipe
  localparam real SCALE   = 2.0 ** Q_FRAC;
  localparam logic [W-1:0] MAX_POS = {1'b0, {(W-1){1'b1}}};

  // One ray in flight, checked when its result comes out
  typedef struct packed {
    logic [31:0]  due;    // Cycle the result must appear in
    logic [W-1:0] dir_x;
    logic [W-1:0] dir_y;
    logic         tie;    // Directed tie, equal magnitudes
  } exp_t;

  logic         i_clk;
  logic         i_rst_n;
  logic         i_ray_valid;
  logic [W-1:0] i_dir_x;
  logic [W-1:0] i_dir_y;
  logic         o_delta_valid;
  logic [W-1:0] o_delta_x;
  logic [W-1:0] o_delta_y;
  logic         o_step_neg_x;
  logic         o_step_neg_y;
  logic         o_sat_x;
  logic         o_sat_y;
  logic         o_near_x;

  exp_t        exp_q[$];  // Scoreboard, oldest ray first
  int          cyc;       // Rising edges seen
  logic [31:0] seed;

  ray_delta_unit #(
    .Q_INT  (Q_INT),
    .Q_FRAC (Q_FRAC)
  ) dut0 (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_ray_valid   (i_ray_valid),
    .i_dir_x       (i_dir_x),
    .i_dir_y       (i_dir_y),
    .o_delta_valid (o_delta_valid),
    .o_delta_x     (o_delta_x),
    .o_delta_y     (o_delta_y),
    .o_step_neg_x  (o_step_neg_x),
    .o_step_neg_y  (o_step_neg_y),
    .o_sat_x       (o_sat_x),
    .o_sat_y       (o_sat_y),
    .o_near_x      (o_near_x)
  );

  always #5 i_clk = ~i_clk;  // 10 ns period

  always @(posedge i_clk) cyc <= cyc + 1;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_mismatch(input string sig, input longint exp_v, input longint got_v);
    fail_run($sformatf("ERR t=%0t %s expected %0d got %0d", $time, sig, exp_v, got_v));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Spread magnitudes over the whole range, down to 0 and 1 LSB
  function automatic logic [W-1:0] rand_dir(input logic [31:0] r_mag, input logic [31:0] r_ctl);
    logic [W-1:0] v;
    v = W'(r_mag >> (8 + (r_ctl % 24)));
    if (r_ctl[31]) v = -v;
    return v;
  endfunction

  function automatic real to_real(input logic signed [W-1:0] v);
    int iv;
    iv = v;  // Sign extends
    return $itor(iv) / SCALE;
  endfunction

  // Per-axis checks of one result
  task automatic check_axis(input string ax, input logic [W-1:0] dir, input logic [W-1:0] delta,
                            input logic step_neg, input logic sat);
    real mag_r;
    real recip;
    real max_r;
    real exp_raw;
    real tol;
    mag_r = to_real(dir);
    if (mag_r < 0.0) mag_r = -mag_r;
    max_r = $itor(MAX_POS) / SCALE;
    recip = (dir == '0) ? 0.0 : 1.0 / mag_r;

    assert (step_neg == dir[W-1])
      else value_mismatch({"o_step_neg_", ax}, dir[W-1], step_neg);

    // Results near the largest value may go either way
    if (dir == '0 || recip > max_r * 1.01) begin
      assert (sat) else value_mismatch({"o_sat_", ax}, 1, sat);
    end else if (recip < max_r * 0.99) begin
      assert (!sat) else value_mismatch({"o_sat_", ax}, 0, sat);
    end
    if (sat) begin
      assert (delta == MAX_POS) else value_mismatch({"o_delta_", ax}, MAX_POS, delta);
    end

    // Accuracy window 1/64 to 16
    if (dir != '0 && mag_r >= 1.0 / 64.0 && mag_r <= 16.0) begin
      exp_raw = recip * SCALE;
      tol     = (exp_raw * 0.01 > 4.0) ? exp_raw * 0.01 : 4.0;
      assert ((($itor(delta) - exp_raw) <= tol) && ((exp_raw - $itor(delta)) <= tol))
        else fail_run($sformatf("ERR t=%0t o_delta_%s expected %f got %f", $time, ax,
                                recip, $itor(delta) / SCALE));
    end
  endtask

  task automatic check_result(input exp_t ent);
    assert (cyc == ent.due) else value_mismatch("o_delta_valid cycle", ent.due, cyc);
    check_axis("x", ent.dir_x, o_delta_x, o_step_neg_x, o_sat_x);
    check_axis("y", ent.dir_y, o_delta_y, o_step_neg_y, o_sat_y);
    assert (o_near_x == (o_delta_x <= o_delta_y))
      else value_mismatch("o_near_x", (o_delta_x <= o_delta_y), o_near_x);
    if (ent.tie) begin
      assert (o_delta_x == o_delta_y) else value_mismatch("o_delta_y", o_delta_x, o_delta_y);
      assert (o_near_x) else value_mismatch("o_near_x", 1, o_near_x);
    end
  endtask

  // Sample on the falling edge, away from the DUT updates
  always @(negedge i_clk) begin : monitor
    exp_t ent;
    if (i_rst_n) begin
      if (o_delta_valid) begin
        assert (exp_q.size() > 0) else fail_run("o_delta_valid pulsed with no ray in flight");
        ent = exp_q.pop_front();
        check_result(ent);
      end else if (exp_q.size() > 0) begin
        assert (exp_q[0].due > cyc) else fail_run("a ray result never came out on time");
      end
    end
  end

  task automatic send_ray(input logic [W-1:0] dx, input logic [W-1:0] dy, input logic tie);
    exp_t ent;
    @(posedge i_clk);
    #1;
    i_ray_valid = 1'b1;
    i_dir_x     = dx;
    i_dir_y     = dy;
    ent.due   = cyc + LATENCY;
    ent.dir_x = dx;
    ent.dir_y = dy;
    ent.tie   = tie;
    exp_q.push_back(ent);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;
      i_ray_valid = 1'b0;
    end
  endtask

  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;
    int          waited;
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_ray_valid = 1'b0;
    i_dir_x     = '0;
    i_dir_y     = '0;
    cyc         = 0;
    seed        = 32'hd267db8a;

    repeat (4) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(negedge i_clk);
    assert ({o_delta_valid, o_delta_x, o_delta_y, o_step_neg_x, o_step_neg_y,
             o_sat_x, o_sat_y, o_near_x} == '0)
      else fail_run("outputs are not all zero after reset");
    idle(6);  // Quiet pipe must stay quiet

    // Directed rays
    send_ray(W'(4096), W'(8192), 1'b0);       // 1.0 and 2.0
    send_ray(W'(64), W'(65536), 1'b0);        // Edges of the accuracy window
    send_ray('0, W'(4096), 1'b0);             // Zero saturates
    send_ray(W'(1), -W'(1), 1'b0);            // Too small to fit
    idle(2);
    send_ray({1'b1, {(W-1){1'b0}}}, MAX_POS, 1'b0);  // Most negative and largest
    send_ray(W'(4096), -W'(4096), 1'b1);
    send_ray(-W'(300), W'(300), 1'b1);
    send_ray('0, '0, 1'b1);                   // Both clamp, still a tie
    idle(3);

    // Random rays, back to back with occasional gaps
    for (int n = 0; n < 200; n++) begin
      seed = xorshift32(seed);
      ra   = seed;
      seed = xorshift32(seed);
      rb   = seed;
      seed = xorshift32(seed);
      rc   = seed;
      send_ray(rand_dir(ra, rc), rand_dir(rb, {rc[15:0], rc[31:16]}), 1'b0);
      if (rc[7:6] == 2'b00) idle(1 + rc[9:8]);
    end
    idle(1);

    waited = 0;
    while (exp_q.size() > 0 && waited < DRAIN_MAX) begin
      @(posedge i_clk);
      waited++;
    end
    @(negedge i_clk);
    if (exp_q.size() != 0) begin
      fail_run("timed out waiting for the last results");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: verilog.f
design/ray_delta_pkg.sv
design/ray_dir_issue.sv
design/reciprocal_lane.sv
design/delta_dist_pack.sv
design/ray_delta_unit.sv
dv/tb_ray_delta_unit.sv

// File: Bender.yml
package:
  name: ray_delta_unit

sources:
  # Package first, then the blocks, top level last
  - files:
      - design/ray_delta_pkg.sv
      - design/ray_dir_issue.sv
      - design/reciprocal_lane.sv
      - design/delta_dist_pack.sv
      - design/ray_delta_unit.sv

  # Testbench, only for simulation
  - target: test
    files:
      - dv/tb_ray_delta_unit.sv
